/* core_pkg.sv */
package core_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // register file index width, 32 registers
    localparam int reg_addr_w = 5;

    // fetch starts here after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes handled by this core
    // anything else decodes as illegal
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    // alu function select
    // pass_b forwards operand b, used by lui
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // control transfer kind for the pc unit
    // nine kinds, so one bit more than three
    typedef enum logic [3:0] {
        br_none     = 4'd0,
        br_eq       = 4'd1,
        br_ne       = 4'd2,
        br_lt       = 4'd3,
        br_ge       = 4'd4,
        br_ltu      = 4'd5,
        br_geu      = 4'd6,
        br_jump     = 4'd7,
        br_jump_reg = 4'd8
    } branch_e;

    // writeback source
    typedef enum logic {
        wb_alu  = 1'b0,
        wb_link = 1'b1
    } wb_sel_e;

    // alu operand a source, pc only for auipc
    typedef enum logic {
        src_a_rs1 = 1'b0,
        src_a_pc  = 1'b1
    } src_a_e;

endpackage

/* core_decoder.sv */
`timescale 1ns/100ps

module core_decoder (
    input  logic [core_pkg::xlen-1:0]       inst_i,
    input  logic                            inst_valid_i,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr_o,
    output logic [core_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic [core_pkg::xlen-1:0]       imm_o,
    output core_pkg::alu_op_e               alu_op_o,
    output core_pkg::src_a_e                src_a_o,
    output logic                            alu_src_imm_o,
    output core_pkg::wb_sel_e               wb_sel_o,
    output core_pkg::branch_e               branch_o,
    output logic                            reg_write_o,
    output logic                            illegal_o
);
    import core_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [xlen-1:0]  imm_i_type;
    logic [xlen-1:0]  imm_u_type;
    logic [xlen-1:0]  imm_b_type;
    logic [xlen-1:0]  imm_j_type;
    logic             legal;
    logic             writes_rd;
    branch_e          branch;

    // shared funct3 map for op and op_imm
    // alt picks sub over add and sra over srl
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // fixed instruction fields
    assign opcode     = opcode_e'(inst_i[6:0]);
    assign rd_addr_o  = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign funct7     = inst_i[31:25];

    // immediates, all sign extended from bit 31
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        // defaults describe a plain add with no writeback
        alu_op_o      = alu_add;
        src_a_o       = src_a_rs1;
        alu_src_imm_o = 1'b0;
        wb_sel_o      = wb_alu;
        branch        = br_none;
        imm_o         = '0;
        writes_rd     = 1'b0;
        legal         = 1'b1;
        case (opcode)
            opc_op: begin
                writes_rd = 1'b1;
                alu_op_o  = alu_from_funct3(funct3, funct7[5]);
                // funct7 0x20 only valid for sub and sra
                if (funct7 == 7'b0100000) begin
                    legal = (funct3 == 3'b000) || (funct3 == 3'b101);
                end else begin
                    legal = (funct7 == 7'b0000000);
                end
            end
            opc_op_imm: begin
                writes_rd     = 1'b1;
                alu_src_imm_o = 1'b1;
                imm_o         = imm_i_type;
                // addi has no sub form, bit 30 is immediate there
                alu_op_o      = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
                // shift amounts are 5 bits, upper bits must be clean
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            opc_lui: begin
                writes_rd     = 1'b1;
                alu_op_o      = alu_pass_b;
                alu_src_imm_o = 1'b1;
                imm_o         = imm_u_type;
            end
            opc_auipc: begin
                writes_rd     = 1'b1;
                src_a_o       = src_a_pc;
                alu_src_imm_o = 1'b1;
                imm_o         = imm_u_type;
            end
            opc_branch: begin
                imm_o = imm_b_type;
                case (funct3)
                    3'b000:  branch = br_eq;
                    3'b001:  branch = br_ne;
                    3'b100:  branch = br_lt;
                    3'b101:  branch = br_ge;
                    3'b110:  branch = br_ltu;
                    3'b111:  branch = br_geu;
                    default: legal = 1'b0;
                endcase
            end
            opc_jal: begin
                writes_rd = 1'b1;
                wb_sel_o  = wb_link;
                branch    = br_jump;
                imm_o     = imm_j_type;
            end
            opc_jalr: begin
                writes_rd = 1'b1;
                wb_sel_o  = wb_link;
                branch    = br_jump_reg;
                imm_o     = imm_i_type;
                legal     = (funct3 == 3'b000);
            end
            // loads, stores, fence, system land here
            default: legal = 1'b0;
        endcase
    end

    // illegal words never redirect the pc
    assign branch_o    = legal ? branch : br_none;
    // x0 writes are dropped here and nowhere else
    assign reg_write_o = inst_valid_i && legal && writes_rd && (rd_addr_o != '0);
    assign illegal_o   = inst_valid_i && !legal;

endmodule

/* core_regfile.sv */
`timescale 1ns/100ps

module core_regfile (
    input  logic                            clk_i,
    input  logic                            we_i,
    input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [core_pkg::xlen-1:0]       wdata_i,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1_i,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2_i,
    output logic [core_pkg::xlen-1:0]       rdata1_o,
    output logic [core_pkg::xlen-1:0]       rdata2_o
);
    import core_pkg::*;

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    // single write port
    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // async reads, x0 reads as zero
    // a same-cycle write is seen only after the edge
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

    // decoder must already have filtered rd == 0
    x0_write_check : assert property (@(posedge clk_i) we_i |-> (waddr_i != '0))
        else $error("regfile: write requested to x0");

endmodule

/* core_alu.sv */
`timescale 1ns/100ps

module core_alu (
    input  core_pkg::alu_op_e         op_i,
    input  logic [core_pkg::xlen-1:0] a_i,
    input  logic [core_pkg::xlen-1:0] b_i,
    output logic [core_pkg::xlen-1:0] result_o
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // rv32i only looks at the low five bits of the shift amount
    assign shamt = b_i[4:0];

    // compare results for slt and sltu
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            alu_add: result_o = a_i + b_i;
            alu_sub: result_o = a_i - b_i;
            alu_sll: result_o = a_i << shamt;
            // compares give a clean 0 or 1
            alu_slt: result_o = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor: result_o = a_i ^ b_i;
            alu_srl: result_o = a_i >> shamt;
            // arithmetic shift, sign bit fills from the left
            alu_sra: result_o = $unsigned($signed(a_i) >>> shamt);
            alu_or: result_o = a_i | b_i;
            alu_and: result_o = a_i & b_i;
            // lui, immediate already shifted by the decoder
            alu_pass_b: result_o = b_i;
            default: result_o = '0;
        endcase
    end

endmodule

/* core_pc_unit.sv */
`timescale 1ns/100ps

module core_pc_unit (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      advance_i,
    input  core_pkg::branch_e         branch_i,
    input  logic [core_pkg::xlen-1:0] rs1_data_i,
    input  logic [core_pkg::xlen-1:0] rs2_data_i,
    input  logic [core_pkg::xlen-1:0] imm_i,
    output logic [core_pkg::xlen-1:0] pc_o,
    output logic [core_pkg::xlen-1:0] link_o
);
    import core_pkg::*;

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_rel_target;
    logic [xlen-1:0] reg_target;
    logic            taken;

    // sequential successor, also the link value
    assign link_o = pc_q + 32'd4;

    // jal and branches are pc relative
    assign pc_rel_target = pc_q + imm_i;
    // jalr drops bit 0 of the sum
    assign reg_target = (rs1_data_i + imm_i) & ~32'd1;

    // branch condition, both signed and unsigned
    always_comb begin
        case (branch_i)
            br_eq:   taken = (rs1_data_i == rs2_data_i);
            br_ne:   taken = (rs1_data_i != rs2_data_i);
            br_lt:   taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            br_ge:   taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            br_ltu:  taken = (rs1_data_i < rs2_data_i);
            br_geu:  taken = (rs1_data_i >= rs2_data_i);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // register target wins, then relative, else fall through
    assign pc_next = (branch_i == br_jump_reg) ? reg_target :
                     taken                     ? pc_rel_target : link_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= reset_pc;
        end else if (advance_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // no C extension, so fetch stays word aligned
    pc_align_check : assert property (@(posedge clk_i) disable iff (reset_i)
        pc_o[1:0] == 2'b00)
        else $error("pc unit: misaligned pc %h", pc_o);

endmodule

/* core_top.sv */
`timescale 1ns/100ps

module core_top (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            inst_valid_i,
    input  logic [core_pkg::xlen-1:0]       inst_i,
    output logic [core_pkg::xlen-1:0]       pc_o,
    output logic                            wb_en_o,
    output logic [core_pkg::reg_addr_w-1:0] wb_addr_o,
    output logic [core_pkg::xlen-1:0]       wb_data_o,
    output logic                            illegal_o
);
    import core_pkg::*;

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    src_a_e                src_a;
    logic                  alu_src_imm;
    wb_sel_e               wb_sel;
    branch_e               branch;
    logic                  reg_write;
    logic                  dec_illegal;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       alu_a;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       link;

    core_decoder u_decoder (
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .imm_o         (imm),
        .alu_op_o      (alu_op),
        .src_a_o       (src_a),
        .alu_src_imm_o (alu_src_imm),
        .wb_sel_o      (wb_sel),
        .branch_o      (branch),
        .reg_write_o   (reg_write),
        .illegal_o     (dec_illegal)
    );

    core_regfile u_regfile (
        .clk_i    (clk_i),
        .we_i     (wb_en_o),
        .waddr_i  (rd_addr),
        .wdata_i  (wb_data_o),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    // operand muxes, pc feeds auipc
    assign alu_a = (src_a == src_a_pc) ? pc_o : rs1_data;
    assign alu_b = alu_src_imm ? imm : rs2_data;

    core_alu u_alu (
        .op_i     (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    core_pc_unit u_pc_unit (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        // only a valid word moves the pc
        .advance_i  (inst_valid_i && !reset_i),
        .branch_i   (branch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .pc_o       (pc_o),
        .link_o     (link)
    );

    // writeback port, quiet while in reset
    assign wb_en_o   = reg_write && !reset_i;
    assign wb_addr_o = rd_addr;
    assign wb_data_o = (wb_sel == wb_link) ? link : alu_result;
    assign illegal_o = dec_illegal && !reset_i;

    // a rejected word just steps over to the next one
    illegal_step_check : assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o |=> (pc_o == $past(pc_o) + 32'd4))
        else $error("core: pc did not step past illegal word");

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 20 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held over the first three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* tb_core.sv */
`timescale 1ns/100ps

module tb_core;
    import core_pkg::*;

    logic                  clk_i;
    logic                  reset_i;
    logic                  inst_valid_i;
    logic [xlen-1:0]       inst_i;
    logic [xlen-1:0]       pc_o;
    logic                  wb_en_o;
    logic [reg_addr_w-1:0] wb_addr_o;
    logic [xlen-1:0]       wb_data_o;
    logic                  illegal_o;

    // program table, one row per word address
    logic [xlen-1:0]       tbl_inst [0:63];
    logic                  tbl_en   [0:63];
    logic [reg_addr_w-1:0] tbl_addr [0:63];
    logic [xlen-1:0]       tbl_data [0:63];
    logic                  tbl_ill  [0:63];
    logic [xlen-1:0]       tbl_next [0:63];
    int                    row_count = 0;

    int              word_errors = 0;
    int              addr_errors = 0;
    int              bit_errors = 0;
    int              cycle_count = 0;
    int              timeout_limit = 0;
    int              idx;
    logic            bubble;
    logic            exp_en;
    logic            exp_ill;
    logic [xlen-1:0] exp_pc;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk_i),
        .reset_o (reset_i)
    );

    core_top DUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_o         (pc_o),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .illegal_o    (illegal_o)
    );

    // instruction encoders, field layout per rv32i
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // branch offset is scattered, bit 0 implied
    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic en, input logic [4:0] addr,
                           input logic [31:0] data, input logic ill,
                           input logic [31:0] next);
        tbl_inst[row_count] = inst;
        tbl_en[row_count]   = en;
        tbl_addr[row_count] = addr;
        tbl_data[row_count] = data;
        tbl_ill[row_count]  = ill;
        tbl_next[row_count] = next;
        row_count++;
    endtask

    // plain register write, falls through to pc+4
    // rd of x0 must not raise the write enable
    task automatic write_row(input logic [31:0] inst, input logic [4:0] rd,
                             input logic [31:0] data);
        add_row(inst, rd != 5'd0, rd, data, 1'b0, 32'(row_count * 4 + 4));
    endtask

    // every branch jumps forward by 8, over one row
    task automatic branch_row(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        logic [31:0] pc;
        pc = 32'(row_count * 4);
        add_row(b_type(13'd8, rs2, rs1, f3), 1'b0, 5'd0, 32'd0, 1'b0,
                taken ? pc + 32'd8 : pc + 32'd4);
    endtask

    // target of a taken jump, never executed
    task automatic skip_row();
        add_row(i_type(12'd1, 5'd0, 3'b000, 5'd31, opc_op_imm), 1'b1, 5'd31, 32'd1, 1'b0,
                32'd0);
    endtask

    task automatic build_table();
        // operand setup: x1 = 0x80000000, x3 = -5, x4 = 7
        write_row(u_type(20'h80000, 5'd1, opc_lui), 5'd1, 32'h8000_0000);
        write_row(u_type(20'h00001, 5'd2, opc_auipc), 5'd2, 32'h0000_1004);
        write_row(i_type(12'hffb, 5'd0, 3'b000, 5'd3, opc_op_imm), 5'd3, 32'hffff_fffb);
        write_row(i_type(12'h007, 5'd0, 3'b000, 5'd4, opc_op_imm), 5'd4, 32'h0000_0007);
        // register-register ops
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b000, 5'd5), 5'd5, 32'h0000_0002);
        write_row(r_type(7'h20, 5'd3, 5'd4, 3'b000, 5'd6), 5'd6, 32'h0000_000c);
        write_row(r_type(7'h00, 5'd4, 5'd4, 3'b001, 5'd7), 5'd7, 32'h0000_0380);
        // slt sees -5 < 7, sltu sees a huge value
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b010, 5'd8), 5'd8, 32'h0000_0001);
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b011, 5'd9), 5'd9, 32'h0000_0000);
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd10), 5'd10, 32'hffff_fffc);
        write_row(r_type(7'h00, 5'd4, 5'd1, 3'b101, 5'd11), 5'd11, 32'h0100_0000);
        write_row(r_type(7'h20, 5'd4, 5'd1, 3'b101, 5'd12), 5'd12, 32'hff00_0000);
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b110, 5'd13), 5'd13, 32'hffff_ffff);
        write_row(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd14), 5'd14, 32'h0000_0003);
        // immediate ops
        write_row(i_type(12'h001, 5'd3, 3'b010, 5'd15, opc_op_imm), 5'd15, 32'h0000_0001);
        write_row(i_type(12'h001, 5'd3, 3'b011, 5'd16, opc_op_imm), 5'd16, 32'h0000_0000);
        write_row(i_type(12'hfff, 5'd4, 3'b100, 5'd17, opc_op_imm), 5'd17, 32'hffff_fff8);
        write_row(i_type(12'h010, 5'd4, 3'b110, 5'd18, opc_op_imm), 5'd18, 32'h0000_0017);
        write_row(i_type(12'h0f0, 5'd3, 3'b111, 5'd19, opc_op_imm), 5'd19, 32'h0000_00f0);
        write_row(i_type(12'h004, 5'd4, 3'b001, 5'd20, opc_op_imm), 5'd20, 32'h0000_0070);
        write_row(i_type(12'h004, 5'd1, 3'b101, 5'd21, opc_op_imm), 5'd21, 32'h0800_0000);
        write_row(i_type(12'h404, 5'd1, 3'b101, 5'd22, opc_op_imm), 5'd22, 32'hf800_0000);
        // rd x0 drops the write, x0 as operand reads zero
        write_row(i_type(12'h001, 5'd4, 3'b000, 5'd0, opc_op_imm), 5'd0, 32'h0000_0008);
        write_row(r_type(7'h00, 5'd4, 5'd0, 3'b000, 5'd23), 5'd23, 32'h0000_0007);
        // each branch taken then not taken
        branch_row(3'b000, 5'd4, 5'd4, 1'b1);
        skip_row();
        branch_row(3'b000, 5'd4, 5'd3, 1'b0);
        branch_row(3'b001, 5'd4, 5'd3, 1'b1);
        skip_row();
        branch_row(3'b001, 5'd4, 5'd4, 1'b0);
        branch_row(3'b100, 5'd3, 5'd4, 1'b1);
        skip_row();
        branch_row(3'b100, 5'd4, 5'd3, 1'b0);
        branch_row(3'b101, 5'd4, 5'd3, 1'b1);
        skip_row();
        branch_row(3'b101, 5'd3, 5'd4, 1'b0);
        branch_row(3'b110, 5'd4, 5'd3, 1'b1);
        skip_row();
        branch_row(3'b110, 5'd3, 5'd4, 1'b0);
        branch_row(3'b111, 5'd3, 5'd4, 1'b1);
        skip_row();
        branch_row(3'b111, 5'd4, 5'd3, 1'b0);
        // jal at 0xa8 links 0xac, lands on 0xb0
        add_row(j_type(21'd8, 5'd24), 1'b1, 5'd24, 32'h0000_00ac, 1'b0, 32'h0000_00b0);
        skip_row();
        write_row(i_type(12'h0c1, 5'd0, 3'b000, 5'd25, opc_op_imm), 5'd25, 32'h0000_00c1);
        // jalr target 0xc1 with bit 0 cleared
        add_row(i_type(12'h000, 5'd25, 3'b000, 5'd26, opc_jalr), 1'b1, 5'd26, 32'h0000_00b8,
                1'b0, 32'h0000_00c0);
        skip_row();
        skip_row();
        // lw and an m-extension funct7, both rejected
        add_row(i_type(12'h000, 5'd0, 3'b010, 5'd27, 7'b0000011), 1'b0, 5'd0, 32'd0, 1'b1,
                32'h0000_00c4);
        add_row(r_type(7'h01, 5'd4, 5'd3, 3'b000, 5'd29), 1'b0, 5'd0, 32'd0, 1'b1,
                32'h0000_00c8);
        write_row(r_type(7'h00, 5'd0, 5'd24, 3'b000, 5'd28), 5'd28, 32'h0000_00ac);
    endtask

    task automatic check_word(input logic [xlen-1:0] act, input logic [xlen-1:0] exp,
                              input string name);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            word_errors++;
        end
    endtask

    task automatic check_addr(input logic [reg_addr_w-1:0] act,
                              input logic [reg_addr_w-1:0] exp, input string name);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            addr_errors++;
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            bit_errors++;
        end
    endtask

    // run limit, room for bubbles and reset
    always @(posedge clk_i) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: program did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        inst_valid_i = 1'b0;
        inst_i = '0;
        void'($urandom(32'h80c6));
        build_table();
        timeout_limit = row_count * 2 + 3 + 20;

        // illegal word offered during reset, outputs stay quiet
        @(negedge clk_i);
        while (reset_i) begin
            inst_valid_i = 1'b1;
            inst_i = tbl_inst[48];
            #2;
            check_bit(wb_en_o, 1'b0, "wb_en_o");
            check_bit(illegal_o, 1'b0, "illegal_o");
            check_word(pc_o, reset_pc, "pc_o");
            @(negedge clk_i);
        end
        check_word(pc_o, reset_pc, "pc_o");

        // first cycle out of reset is always a bubble
        bubble = 1'b1;
        while (pc_o < 32'(row_count * 4)) begin
            idx = int'(pc_o >> 2);
            inst_i = tbl_inst[idx];
            if (bubble) begin
                inst_valid_i = 1'b0;
                exp_en = 1'b0;
                exp_ill = 1'b0;
                exp_pc = pc_o;
            end else begin
                inst_valid_i = 1'b1;
                exp_en = tbl_en[idx];
                exp_ill = tbl_ill[idx];
                exp_pc = tbl_next[idx];
            end
            #2;
            check_bit(wb_en_o, exp_en, "wb_en_o");
            check_bit(illegal_o, exp_ill, "illegal_o");
            if (exp_en) begin
                check_addr(wb_addr_o, tbl_addr[idx], "wb_addr_o");
                check_word(wb_data_o, tbl_data[idx], "wb_data_o");
            end
            @(posedge clk_i);
            #2;
            check_word(pc_o, exp_pc, "pc_o");
            @(negedge clk_i);
            bubble = ($urandom % 4) == 0;
        end

        $display("done: %0d word errors, %0d address errors, %0d bit errors",
                 word_errors, addr_errors, bit_errors);
        if (word_errors + addr_errors + bit_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
core_pkg.sv
core_decoder.sv
core_regfile.sv
core_alu.sv
core_pc_unit.sv
core_top.sv
tb_clock_gen.sv
tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_core -o sim_core
./obj_dir/sim_core | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
